// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - src
    files:
      - src/icache_pkg.sv
      - src/icache_req_buf.sv
      - src/icache_arrays.sv
      - src/icache_ctrl_fsm.sv
      - src/icache_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/icache_props.sv
      - tests/icache_tb.sv

// File: project.f
+incdir+src
src/icache_pkg.sv
src/icache_req_buf.sv
src/icache_arrays.sv
src/icache_ctrl_fsm.sv
src/icache_top.sv
tests/icache_props.sv
tests/icache_tb.sv

// File: src/icache_arrays.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_arrays
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  index_t   rd_index,    // set to read on this edge
    input  addr_t    buf_addr,
    input  way_vec_t data_we,     // refill: tag, valid and line
    input  line_t    refill_line,
    input  way_vec_t tag_inval,
    input  logic     tag_init,
    input  way_vec_t use_way,
    output way_vec_t hit,
    output word_t    hit_word,
    output logic     lru_way
);

    localparam int num_sets = 1 << `ICACHE_INDEX_W;

    tag_t  tag_mem  [`ICACHE_WAYS][num_sets];
    line_t line_mem [`ICACHE_WAYS][num_sets];

    logic [num_sets-1:0] valid_q [`ICACHE_WAYS];
    logic [num_sets-1:0] lru_q; // victim way per set

    index_t rd_index_q;
    index_t buf_index;
    tag_t   buf_tag;
    logic   [`ICACHE_INDEX_LSB-`ICACHE_OFFSET_LSB-1:0] word_sel;
    line_t  hit_line;

    assign buf_index = buf_addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
    assign buf_tag   = buf_addr[31:`ICACHE_TAG_LSB];
    assign word_sel  = buf_addr[`ICACHE_INDEX_LSB-1:`ICACHE_OFFSET_LSB];

    ////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        rd_index_q <= rd_index;
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (data_we[w]) begin
                tag_mem[w][buf_index]  <= buf_tag;
                line_mem[w][buf_index] <= refill_line;
            end else if (tag_init && (w == int'(buf_addr[0]))) begin
                tag_mem[w][buf_index]  <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (data_we[w]) begin
                    valid_q[w][buf_index] <= 1'b1;
                end else if (tag_inval[w] || (tag_init && (w == int'(buf_addr[0])))) begin
                    valid_q[w][buf_index] <= 1'b0;
                end
            end
        end
    end

    // the other way becomes the victim
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use_way[0]) begin
            lru_q[buf_index] <= 1'b1;
        end else if (use_way[1]) begin
            lru_q[buf_index] <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // compare and select
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit[w] = valid_q[w][rd_index_q] && (tag_mem[w][rd_index_q] == buf_tag);
            if (hit[w]) begin
                hit_line = hit_line | line_mem[w][rd_index_q];
            end
        end
    end

    assign hit_word = hit_line[word_sel*32 +: 32];
    assign lru_way  = lru_q[buf_index];

endmodule

`default_nettype wire

// File: src/icache_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl_fsm
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        fetch_valid,
    input  logic        buf_uncached,
    input  logic        buf_op,
    input  cacheop_t    buf_opcode,
    input  addr_t       buf_addr,
    input  logic        stall,
    input  logic        flush,
    input  way_vec_t    hit,
    input  logic        lru_way,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    output logic        ready,
    output logic        buf_we,
    output logic        rdata_valid,
    output logic        rdata_from_mem,
    output logic        op_ack,
    output logic        mem_req,
    output way_vec_t    data_we,
    output way_vec_t    tag_inval,
    output logic        tag_init,
    output way_vec_t    use_way
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    ctrl_state_t cur_state;
    ctrl_state_t resume;     // where to go when ready is high

    logic     rstn_q;
    logic     ready_int;
    logic     miss;
    way_vec_t refill_way;
    way_vec_t idx_way;

    always_ff @(posedge clk) begin
        rstn_q <= rstn;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // an accepted operation spends its first cycle as the operation state
    assign cur_state = (state == st_lookup && buf_op) ? st_operation : state;

    assign miss       = ~|hit || buf_uncached; // uncached never hits
    assign refill_way = lru_way ? way_vec_t'(2'b10) : way_vec_t'(2'b01);
    assign idx_way    = buf_addr[0] ? way_vec_t'(2'b10) : way_vec_t'(2'b01);
    assign resume     = (fetch_valid && rstn_q) ? st_lookup : st_idle;

    assign ready  = ready_int & rstn_q; // low in first cycle out of reset
    assign buf_we = ready & fetch_valid;

    always_comb begin
        next_state     = cur_state;
        ready_int      = 1'b0;
        rdata_valid    = 1'b0;
        rdata_from_mem = 1'b0;
        op_ack         = 1'b0;
        mem_req        = 1'b0;
        data_we        = '0;
        tag_inval      = '0;
        tag_init       = 1'b0;
        use_way        = '0;
        case (cur_state)
            st_idle: begin
                ready_int  = 1'b1;
                next_state = resume;
            end
            st_lookup: begin
                if (flush) begin
                    // drop the pending fetch
                    ready_int  = 1'b1;
                    next_state = st_flush;
                end else if (miss) begin
                    mem_req = 1'b1;
                    if (buf_uncached) begin
                        tag_inval = hit; // stale cached copy
                    end
                    next_state = mem_addr_ok ? st_miss_wait : st_miss_req;
                end else begin
                    rdata_valid = 1'b1;
                    use_way     = hit;
                    if (stall) begin
                        next_state = st_lookup; // hold word
                    end else begin
                        ready_int  = 1'b1;
                        next_state = resume;
                    end
                end
            end
            st_miss_req: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    next_state = st_miss_wait;
                end
            end
            st_miss_wait: begin
                if (mem_data_ok) begin
                    rdata_valid    = 1'b1;
                    rdata_from_mem = 1'b1;
                    ready_int      = 1'b1;
                    if (!buf_uncached) begin
                        data_we = refill_way;
                        use_way = refill_way;
                    end
                    next_state = resume;
                end
            end
            st_operation: begin
                ready_int = 1'b1;
                if (flush) begin
                    next_state = st_flush;
                end else begin
                    op_ack = 1'b1;
                    case (buf_opcode)
                        op_tag_init:  tag_init  = 1'b1;
                        op_idx_inval: tag_inval = idx_way; // way from addr bit 0
                        op_hit_inval: tag_inval = hit;
                        default: ;
                    endcase
                    next_state = resume;
                end
            end
            st_flush: begin
                // anything accepted while flush is high is discarded
                ready_int  = 1'b1;
                next_state = flush ? st_flush : resume;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// geometry
`define ICACHE_INDEX_W 4 // 16 sets
`define ICACHE_WAYS 2

// fetch address fields
//   [31:8] tag
//   [7:4]  set index
//   [3:2]  word in line
`define ICACHE_OFFSET_LSB 2
`define ICACHE_INDEX_LSB 4
`define ICACHE_TAG_LSB 8

`endif

// File: src/icache_pkg.sv
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    typedef logic [31:0]                  addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [127:0]                 line_t; // word n at [32n+31:32n]
    typedef logic [31:`ICACHE_TAG_LSB]    tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]   index_t;
    typedef logic [`ICACHE_WAYS-1:0]      way_vec_t; // one-hot per way

    typedef logic [1:0] cacheop_t;

    localparam cacheop_t op_tag_init  = 2'd0;
    localparam cacheop_t op_idx_inval = 2'd1;
    localparam cacheop_t op_hit_inval = 2'd2;
    localparam cacheop_t op_nop       = 2'd3;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss_req,
        st_miss_wait,
        st_operation,
        st_flush
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/icache_req_buf.sv
`timescale 1ns/1ps
`default_nettype none

module icache_req_buf
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     we,       // acceptance strobe
    input  addr_t    addr,
    input  logic     uncached,
    input  logic     op,
    input  cacheop_t opcode,
    output addr_t    buf_addr,
    output logic     buf_uncached,
    output logic     buf_op,
    output cacheop_t buf_opcode
);

    // holds the accepted request until the next acceptance edge
    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_addr     <= '0;
            buf_uncached <= 1'b0;
            buf_op       <= 1'b0;
            buf_opcode   <= op_nop;
        end else if (we) begin
            buf_addr     <= addr;
            buf_uncached <= uncached;
            buf_op       <= op;
            buf_opcode   <= opcode;
        end
    end

endmodule

`default_nettype wire

// File: src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    // pipeline side
    input  logic     fetch_valid,
    input  addr_t    fetch_addr,
    input  logic     fetch_uncached,
    input  logic     fetch_op,
    input  cacheop_t fetch_opcode,
    input  logic     stall,
    input  logic     flush,
    output logic     ready,
    output word_t    rdata,
    output logic     rdata_valid,
    output logic     op_ack,
    // memory side
    output logic     mem_req,
    output addr_t    mem_addr,
    output logic     mem_uncached,
    input  logic     mem_addr_ok,
    input  logic     mem_data_ok,
    input  line_t    mem_rdata
);

    logic     buf_we;
    addr_t    buf_addr;
    logic     buf_uncached;
    logic     buf_op;
    cacheop_t buf_opcode;
    index_t   rd_index;
    way_vec_t hit;
    word_t    hit_word;
    logic     lru_way;
    logic     rdata_from_mem;
    way_vec_t data_we;
    way_vec_t tag_inval;
    logic     tag_init;
    way_vec_t use_way;
    logic     [`ICACHE_INDEX_LSB-`ICACHE_OFFSET_LSB-1:0] word_sel;

    // new set on acceptance, otherwise keep the buffered one
    assign rd_index = buf_we ? fetch_addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB]
                             : buf_addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];

    assign word_sel     = buf_addr[`ICACHE_INDEX_LSB-1:`ICACHE_OFFSET_LSB];
    assign mem_addr     = {buf_addr[31:`ICACHE_INDEX_LSB], {`ICACHE_INDEX_LSB{1'b0}}};
    assign mem_uncached = buf_uncached;
    assign rdata        = rdata_from_mem ? mem_rdata[word_sel*32 +: 32] : hit_word;

    icache_req_buf icache_req_buf_i (
        .clk          (clk),
        .rstn         (rstn),
        .we           (buf_we),
        .addr         (fetch_addr),
        .uncached     (fetch_uncached),
        .op           (fetch_op),
        .opcode       (fetch_opcode),
        .buf_addr     (buf_addr),
        .buf_uncached (buf_uncached),
        .buf_op       (buf_op),
        .buf_opcode   (buf_opcode)
    );

    icache_arrays icache_arrays_i (
        .clk         (clk),
        .rstn        (rstn),
        .rd_index    (rd_index),
        .buf_addr    (buf_addr),
        .data_we     (data_we),
        .refill_line (mem_rdata),
        .tag_inval   (tag_inval),
        .tag_init    (tag_init),
        .use_way     (use_way),
        .hit         (hit),
        .hit_word    (hit_word),
        .lru_way     (lru_way)
    );

    icache_ctrl_fsm icache_ctrl_fsm_i (
        .clk            (clk),
        .rstn           (rstn),
        .fetch_valid    (fetch_valid),
        .buf_uncached   (buf_uncached),
        .buf_op         (buf_op),
        .buf_opcode     (buf_opcode),
        .buf_addr       (buf_addr),
        .stall          (stall),
        .flush          (flush),
        .hit            (hit),
        .lru_way        (lru_way),
        .mem_addr_ok    (mem_addr_ok),
        .mem_data_ok    (mem_data_ok),
        .ready          (ready),
        .buf_we         (buf_we),
        .rdata_valid    (rdata_valid),
        .rdata_from_mem (rdata_from_mem),
        .op_ack         (op_ack),
        .mem_req        (mem_req),
        .data_we        (data_we),
        .tag_inval      (tag_inval),
        .tag_init       (tag_init),
        .use_way        (use_way)
    );

endmodule

`default_nettype wire

// File: tests/icache_props.sv
`timescale 1ns/1ps
`default_nettype none

module icache_props (
    input logic clk,
    input logic rstn,
    input logic ready,
    input logic mem_req,
    input logic mem_addr_ok,
    input logic rdata_valid,
    input logic op_ack
);

    // first cycle out of reset
    ready_low_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !ready)
        else $error("ready high in the first cycle after reset");

    req_held_until_addr_ok: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_addr_ok) |=> mem_req)
        else $error("mem_req dropped before mem_addr_ok");

    data_and_ack_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(rdata_valid && op_ack))
        else $error("rdata_valid and op_ack high together");

endmodule

bind icache_ctrl_fsm icache_props icache_props_i (.*);

`default_nettype wire

// File: tests/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int max_cycles = 4000; // run limit

    logic     clk;
    logic     rstn;
    logic     fetch_valid;
    addr_t    fetch_addr;
    logic     fetch_uncached;
    logic     fetch_op;
    cacheop_t fetch_opcode;
    logic     stall;
    logic     flush;
    logic     ready;
    word_t    rdata;
    logic     rdata_valid;
    logic     op_ack;
    logic     mem_req;
    addr_t    mem_addr;
    logic     mem_uncached;
    logic     mem_addr_ok;
    logic     mem_data_ok;
    line_t    mem_rdata;

    int       mem_phase;    // 0 idle, 1 address phase, 2 data phase
    int       mem_delay;
    addr_t    mem_line;
    int       cycle_count;
    int       req_count;    // mem_req rises seen so far
    addr_t    req_addr;
    logic     req_uncached;
    logic     mem_req_q;

    // reference tags, valid bits and victim way per set
    tag_t     ref_tag   [2][16];
    logic     ref_valid [2][16];
    logic     ref_lru   [16];

    icache_top icache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////
    // models
    ////////////////////////////////////////////////////////////////////

    function automatic index_t set_of(addr_t a);
        return a[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
    endfunction

    // word n is the line address plus n with the upper half scrambled
    function automatic word_t model_word(addr_t a);
        return ({a[31:4], 4'b0000} + 32'(a[3:2])) ^ 32'h5a5a0000;
    endfunction

    function automatic line_t model_line(addr_t a);
        line_t l;
        for (int n = 0; n < 4; n++) begin
            l[n*32 +: 32] = model_word({a[31:4], 2'(n), 2'b00});
        end
        return l;
    endfunction

    function automatic int ref_hit_way(addr_t a);
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][set_of(a)] && (ref_tag[w][set_of(a)] == a[31:8])) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic void ref_fetch(addr_t a, logic uncached);
        int     w;
        index_t s;
        w = ref_hit_way(a);
        s = set_of(a);
        if (uncached) begin
            if (w >= 0) begin
                ref_valid[w][s] = 1'b0; // stale cached copy dropped
            end
        end else if (w >= 0) begin
            ref_lru[s] = (w == 0);
        end else begin
            w = int'(ref_lru[s]); // refill goes to the victim
            ref_valid[w][s] = 1'b1;
            ref_tag[w][s]   = a[31:8];
            ref_lru[s]      = (w == 0);
        end
    endfunction

    // line memory with random address and data latency
    initial begin
        void'($urandom(32'hb1f3));
        forever begin
            @(negedge clk);
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            if (!rstn) begin
                mem_phase = 0;
                mem_delay = 0;
            end else begin
                if (mem_phase == 0 && mem_req) begin
                    mem_line  = mem_addr;
                    mem_delay = $urandom % 3;
                    mem_phase = 1;
                end else if (mem_delay > 0) begin
                    mem_delay = mem_delay - 1;
                end
                if (mem_phase == 1 && mem_delay == 0) begin
                    mem_addr_ok <= 1'b1;
                    mem_delay = 1 + ($urandom % 4);
                    mem_phase = 2;
                end else if (mem_phase == 2 && mem_delay == 0) begin
                    mem_data_ok <= 1'b1;
                    mem_rdata   <= model_line(mem_line);
                    mem_phase = 0;
                end
            end
        end
    end

    // request counter and run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (mem_req && !mem_req_q) begin
            req_count    = req_count + 1;
            req_addr     = mem_addr;
            req_uncached = mem_uncached;
        end
        mem_req_q = mem_req;
        if (cycle_count >= max_cycles) begin
            $display("SOME TESTS FAILED");
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // returns on the falling edge after the acceptance edge
    task automatic issue_request(input addr_t a, input logic uncached, input logic op,
                                 input cacheop_t code);
        fetch_valid    <= 1'b1;
        fetch_addr     <= a;
        fetch_uncached <= uncached;
        fetch_op       <= op;
        fetch_opcode   <= code;
        do @(posedge clk); while (!ready);
        @(negedge clk);
        fetch_valid <= 1'b0;
        fetch_op    <= 1'b0;
    endtask

    task automatic fetch_word(input addr_t a, input logic uncached);
        int   reqs;
        int   wait_n;
        logic exp_miss;
        exp_miss = uncached || (ref_hit_way(a) < 0);
        reqs     = req_count;
        issue_request(a, uncached, 1'b0, op_nop);
        wait_n = 1;
        @(posedge clk);
        while (!rdata_valid) begin
            wait_n = wait_n + 1;
            @(posedge clk);
        end
        check(rdata, model_word(a), "fetch data");
        if (!exp_miss) begin
            check(wait_n, 1, "hit latency");
        end
        @(negedge clk);
        check(req_count - reqs, 32'(exp_miss), "memory requests per fetch");
        if (exp_miss) begin
            check(req_addr, {a[31:4], 4'b0000}, "line address");
            check(req_uncached, uncached, "mem_uncached");
        end
        ref_fetch(a, uncached);
    endtask

    task automatic cache_op(input cacheop_t code, input addr_t a);
        int     w;
        index_t s;
        s = set_of(a);
        issue_request(a, 1'b0, 1'b1, code);
        @(posedge clk);
        check(op_ack, 1'b1, "op_ack one cycle after operation");
        @(negedge clk);
        case (code)
            op_idx_inval: ref_valid[a[0]][s] = 1'b0;
            op_hit_inval: begin
                w = ref_hit_way(a);
                if (w >= 0) begin
                    ref_valid[w][s] = 1'b0;
                end
            end
            op_tag_init: begin
                ref_valid[a[0]][s] = 1'b0;
                ref_tag[a[0]][s]   = '0;
            end
            default: ;
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////

    task automatic test_miss_then_hit();
        fetch_word(32'h1000_0104, 1'b0);
        fetch_word(32'h1000_010c, 1'b0); // same line
    endtask

    task automatic test_lru();
        fetch_word(32'h0000_1130, 1'b0); // A
        fetch_word(32'h0000_2134, 1'b0); // B
        fetch_word(32'h0000_1138, 1'b0); // A again
        fetch_word(32'h0000_313c, 1'b0); // C evicts B
        fetch_word(32'h0000_1130, 1'b0);
        fetch_word(32'h0000_2134, 1'b0);
    endtask

    task automatic test_uncached();
        fetch_word(32'h8000_0048, 1'b1);
        fetch_word(32'h8000_0048, 1'b1);
    endtask

    task automatic test_cache_ops();
        int w;
        fetch_word(32'h0000_9250, 1'b0);
        fetch_word(32'h0000_4250, 1'b0); // lands in way 1
        w = ref_hit_way(32'h0000_4250);
        cache_op(op_idx_inval, 32'h0000_4250 | w); // bit 0 picks the way
        fetch_word(32'h0000_9250, 1'b0); // other way untouched
        fetch_word(32'h0000_4250, 1'b0);
        fetch_word(32'h0000_5260, 1'b0);
        cache_op(op_hit_inval, 32'h0000_5260);
        fetch_word(32'h0000_5264, 1'b0);
        fetch_word(32'h0000_6270, 1'b0);
        w = ref_hit_way(32'h0000_6270);
        cache_op(op_tag_init, 32'h0000_6270 | w);
        fetch_word(32'h0000_6278, 1'b0);
    endtask

    task automatic test_stall_flush();
        int reqs;
        fetch_word(32'h0000_7384, 1'b0);
        stall <= 1'b1;
        issue_request(32'h0000_7388, 1'b0, 1'b0, op_nop);
        repeat (3) begin
            @(posedge clk);
            check(rdata_valid, 1'b1, "rdata_valid held under stall");
            check(rdata, model_word(32'h0000_7388), "rdata held under stall");
            check(ready, 1'b0, "ready under stall");
        end
        @(negedge clk);
        stall <= 1'b0;
        @(posedge clk);
        check(rdata_valid, 1'b1, "rdata_valid as stall drops");
        check(ready, 1'b1, "ready as stall drops");
        @(posedge clk);
        check(rdata_valid, 1'b0, "rdata_valid after stall");
        @(negedge clk);
        ref_fetch(32'h0000_7388, 1'b0);
        // flush held through the lookup cycle
        reqs = req_count;
        flush <= 1'b1;
        issue_request(32'h0000_8394, 1'b0, 1'b0, op_nop);
        @(posedge clk);
        check(rdata_valid, 1'b0, "rdata_valid on flushed fetch");
        check(mem_req, 1'b0, "mem_req on flushed fetch");
        @(negedge clk);
        flush <= 1'b0;
        @(posedge clk);
        check(rdata_valid, 1'b0, "rdata_valid in flush state");
        @(negedge clk);
        check(req_count - reqs, 0, "requests for flushed fetch");
        fetch_word(32'h0000_8394, 1'b0); // still a miss
    endtask

    initial begin
        rstn           = 1'b0;
        fetch_valid    = 1'b0;
        fetch_addr     = '0;
        fetch_uncached = 1'b0;
        fetch_op       = 1'b0;
        fetch_opcode   = op_nop;
        stall          = 1'b0;
        flush          = 1'b0;
        mem_addr_ok    = 1'b0;
        mem_data_ok    = 1'b0;
        mem_rdata      = '0;
        cycle_count    = 0;
        req_count      = 0;
        mem_req_q      = 1'b0;
        for (int s = 0; s < 16; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_valid[w][s] = 1'b0;
                ref_tag[w][s]   = '0;
            end
        end
        repeat (8) @(negedge clk);
        rstn <= 1'b1;
        test_miss_then_hit();
        test_lru();
        test_uncached();
        test_cache_ops();
        test_stall_flush();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
